// ==== dv/accum_core_tb.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module accum_core_tb;
   import accum_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int MAX_TESTS  = 32;
   localparam int MAX_WORDS  = 16;
   localparam int HALT_LIMIT = 40;

   logic              clock;
   logic              reset;
   logic              load_en;
   logic [`PC_W-1:0]  load_addr;
   prog_word_t        load_word;
   logic              run;
   core_status_t      status;

   string             test_name [MAX_TESTS];
   prog_word_t        test_prog [MAX_TESTS][MAX_WORDS];
   int                test_len  [MAX_TESTS];
   logic [`ACC_W-1:0] test_acc  [MAX_TESTS];
   logic              test_err  [MAX_TESTS];
   prog_word_t        build_q [$];
   int                n_tests    = 0;
   int                n_failed   = 0;
   bit                table_done = 1'b0;
   bit                test_failed;
   integer            seed = 30;

   accum_core accum_core_i (
      .clock     (clock),
      .reset     (reset),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_word (load_word),
      .run       (run),
      .status    (status)
   );

   initial begin
      clock = 1'b0;
      forever #(CLK_PERIOD / 2) clock = ~clock;
   end

   function automatic prog_word_t alu_word(alu_op_t op, logic [7:0] imm);
      prog_word_t w;
      w.dev  = DEV_ALU;
      w.body = {op, imm};
      return w;
   endfunction

   function automatic prog_word_t reg_word(reg_op_t op, logic [2:0] sel);
      prog_word_t w;
      w.dev  = DEV_REG;
      w.body = {op, 7'b0, sel};
      return w;
   endfunction

   function automatic prog_word_t seq_word(seq_op_t op, logic [7:0] target);
      prog_word_t w;
      w.dev  = DEV_SEQ;
      w.body = {op, 2'b0, target};
      return w;
   endfunction

   function automatic prog_word_t illegal_word(logic [3:0] dev);
      prog_word_t w;
      w.dev  = dev_t'(dev);
      w.body = '0;
      return w;
   endfunction

   // accumulator rules for the non-compare ops
   function automatic logic [7:0] alu_model(alu_op_t op, logic [7:0] a, logic [7:0] b);
      case (op)
         LDI:     return b;
         ADD:     return a + b;  // mod 256
         SUB:     return a - b;
         NOT:     return ~a;
         AND:     return a & b;
         IOR:     return a | b;
         XOR:     return a ^ b;
         SHL:     return {a[6:0], 1'b0};
         SHR:     return {1'b0, a[7:1]};
         default: return a;
      endcase
   endfunction

   task automatic add_test(string name, logic [7:0] exp_acc, logic exp_err);
      test_name[n_tests] = name;
      test_len[n_tests]  = build_q.size();
      test_acc[n_tests]  = exp_acc;
      test_err[n_tests]  = exp_err;
      for (int i = 0; i < build_q.size(); i++) begin
         test_prog[n_tests][i] = build_q[i];
      end
      build_q.delete();
      n_tests++;
   endtask

   task automatic build_table();
      alu_op_t    chain_ops [9] = '{LDI, ADD, SUB, AND, IOR, XOR, NOT, SHL, SHR};
      alu_op_t    cmp_ops [6]   = '{EQL, NEQ, LTS, LTE, GTS, GTE};
      logic [2:0] cmp_bits [6]  = '{3'b100, 3'b011, 3'b010, 3'b110, 3'b001, 3'b101};
      logic [7:0] cmp_imm [3]   = '{8'h40, 8'h80, 8'h10};  // acc is 0x40
      string      cmp_case [3]  = '{"equal", "acc_below", "acc_above"};
      logic [7:0] acc;
      logic [7:0] imm;
      for (int t = 0; t < 2; t++) begin
         acc = 8'h00;
         foreach (chain_ops[k]) begin
            imm = 8'($random(seed));
            build_q.push_back(alu_word(chain_ops[k], imm));
            acc = alu_model(chain_ops[k], acc, imm);
         end
         build_q.push_back(seq_word(HLT, 8'h00));
         add_test($sformatf("alu_chain_%0d", t), acc, 1'b0);
      end
      foreach (cmp_ops[k]) begin
         for (int c = 0; c < 3; c++) begin
            build_q.push_back(alu_word(LDI, 8'h40));
            build_q.push_back(alu_word(cmp_ops[k], cmp_imm[c]));
            build_q.push_back(seq_word(HLT, 8'h00));
            add_test($sformatf("%s_%s", cmp_ops[k].name(), cmp_case[c]),
                     {7'b0, cmp_bits[k][2-c]}, 1'b0);  // bits are {eq, lt, gt}
         end
      end
      build_q = '{alu_word(LDI, 8'h5a), reg_word(STA, 3'd3), alu_word(LDI, 8'h99),
                  reg_word(LDA, 3'd3), seq_word(HLT, 8'h00)};
      add_test("sta_lda", 8'h5a, 1'b0);
      build_q = '{alu_word(LDI, 8'h5a), reg_word(STA, 3'd3), alu_word(LDI, 8'h99),
                  reg_word(INC, 3'd3), reg_word(INC, 3'd3), reg_word(DEC, 3'd3),
                  reg_word(LDA, 3'd3), seq_word(HLT, 8'h00)};
      add_test("inc_inc_dec", 8'h5b, 1'b0);
      // r1 counts down, r2 counts passes, 5 - 5 leaves zero
      build_q = '{alu_word(LDI, 8'h05), reg_word(STA, 3'd1), reg_word(DEC, 3'd1),
                  reg_word(INC, 3'd2), reg_word(LDA, 3'd1), seq_word(JNZ, 8'h02),
                  reg_word(LDA, 3'd2), alu_word(SUB, 8'h05), seq_word(HLT, 8'h00)};
      add_test("countdown_loop", 8'h00, 1'b0);
      build_q = '{alu_word(LDI, 8'h3c), alu_word(ADD, 8'h01), illegal_word(4'd7),
                  alu_word(LDI, 8'hff), seq_word(HLT, 8'h00)};
      add_test("illegal_dev", 8'h3d, 1'b1);
      build_q = '{alu_word(LDI, 8'h21), alu_word(ADD, 8'h21), seq_word(HLT, 8'h00)};
      add_test("run_after_error", 8'h42, 1'b0);
      build_q = '{alu_word(LDI, 8'h11), seq_word(JMP, 8'h03), alu_word(LDI, 8'hee),
                  alu_word(ADD, 8'h01), seq_word(HLT, 8'h00)};
      add_test("jmp_skip", 8'h12, 1'b0);
      build_q = '{alu_word(LDI, 8'h00), seq_word(JZ, 8'h03), alu_word(LDI, 8'h77),
                  alu_word(ADD, 8'h20), seq_word(HLT, 8'h00)};
      add_test("jz_skip", 8'h20, 1'b0);
   endtask

   task automatic apply_reset();
      @(posedge clock);
      #1;
      reset = 1'b1;
      repeat (4) @(posedge clock);
      #1;
      reset = 1'b0;
   endtask

   task automatic load_program(int t);
      for (int i = 0; i < test_len[t]; i++) begin
         load_en   = 1'b1;
         load_addr = 8'(i);
         load_word = test_prog[t][i];
         @(posedge clock);
         #1;
      end
      load_en = 1'b0;
   endtask

   task automatic pulse_run();
      run = 1'b1;
      @(posedge clock);
      #1;
      run = 1'b0;
   endtask

   task automatic wait_halt(string name, output bit seen);
      seen = 1'b0;
      for (int n = 0; n < HALT_LIMIT && !seen; n++) begin
         @(posedge clock);
         #1;
         seen = status.halted;
      end
      if (!seen) begin
         $display("test %s did not halt within %0d cycles", name, HALT_LIMIT);
         test_failed = 1'b1;
      end
   endtask

   task automatic check_reset_status(string name, core_status_t got);
      if (got !== '0) begin
         $display("Mismatch %s reset status expected 0x000 actual 0x%03h", name, got);
         test_failed = 1'b1;
      end
   endtask

   task automatic check_status(string name, core_status_t got, logic [7:0] exp_acc,
                               logic exp_err);
      if (got.acc !== exp_acc) begin
         $display("Mismatch %s acc expected 0x%02h actual 0x%02h", name, exp_acc, got.acc);
         test_failed = 1'b1;
      end
      if (got.error !== exp_err) begin
         $display("Mismatch %s error expected %0b actual %0b", name, exp_err, got.error);
         test_failed = 1'b1;
      end
   endtask

   initial begin
      bit seen;
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_word = '0;
      run       = 1'b0;
      build_table();
      table_done = 1'b1;
      for (int t = 0; t < n_tests; t++) begin
         test_failed = 1'b0;
         apply_reset();
         check_reset_status(test_name[t], status);
         load_program(t);
         pulse_run();
         wait_halt(test_name[t], seen);
         if (seen) begin
            check_status(test_name[t], status, test_acc[t], test_err[t]);
         end
         if (test_failed) begin
            n_failed++;
         end
         $display("test %-20s %s", test_name[t], test_failed ? "failed" : "ok");
      end
      $display("summary: %0d tests, %0d passed, %0d failed",
               n_tests, n_tests - n_failed, n_failed);
      if (n_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // 64 cycles per test plus slack
   initial begin
      wait (table_done);
      #((n_tests * 64 + 100) * CLK_PERIOD);
      $display("watchdog: tests did not finish within %0d cycles", n_tests * 64 + 100);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== hdl/accum_config.svh ====
`ifndef ACCUM_CONFIG_SVH
`define ACCUM_CONFIG_SVH

`define ACC_W     8
`define IMM_W     8
`define PC_W      8
`define MEM_DEPTH 256
`define REG_N     8
`define REG_SEL_W 3

// alu state codes, 2'd3 is never entered
`define ALU_ST_RESET 2'd0
`define ALU_ST_READY 2'd1
`define ALU_ST_ERROR 2'd2

`endif

// ==== hdl/accum_core.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module accum_core (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    load_en,
   input  logic [`PC_W-1:0]        load_addr,
   input  accum_pkg::prog_word_t   load_word,
   input  logic                    run,
   output accum_pkg::core_status_t status
);
   import accum_pkg::*;

   prog_word_t            word;
   logic [`PC_W-1:0]      pc;
   logic [`ACC_W-1:0]     acc;
   logic [`ACC_W-1:0]     rd_data;
   logic                  alu_ready;
   logic                  alu_error;
   logic                  alu_en;
   alu_inst_t             alu_inst;
   logic                  reg_en;
   reg_op_t               reg_op;
   logic [`REG_SEL_W-1:0] reg_sel;
   logic                  halted;
   logic                  error;

   prog_mem prog_mem_i (
      .clock     (clock),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_word (load_word),
      .pc        (pc),
      .word      (word)
   );

   seq_control seq_control_i (
      .clock     (clock),
      .reset     (reset),
      .run       (run),
      .word      (word),
      .pc        (pc),
      .acc       (acc),
      .rd_data   (rd_data),
      .alu_ready (alu_ready),
      .alu_error (alu_error),
      .alu_en    (alu_en),
      .alu_inst  (alu_inst),
      .reg_en    (reg_en),
      .reg_op    (reg_op),
      .reg_sel   (reg_sel),
      .halted    (halted),
      .error     (error)
   );

   alu alu_i (
      .clock    (clock),
      .reset    (reset),
      .alu_en   (alu_en),
      .alu_inst (alu_inst),
      .acc      (acc),
      .ready    (alu_ready),
      .error    (alu_error)
   );

   reg_bank reg_bank_i (
      .clock   (clock),
      .reset   (reset),
      .reg_en  (reg_en),
      .reg_op  (reg_op),
      .reg_sel (reg_sel),
      .acc     (acc),
      .rd_data (rd_data)
   );

   assign status = '{acc: acc, halted: halted, error: error};

endmodule

// ==== hdl/accum_pkg.sv ====
`include "accum_config.svh"

package accum_pkg;

   typedef enum logic [3:0] {
      NOP, LDI, ADD, SUB, NOT, AND, IOR, XOR,
      SHL, SHR, EQL, NEQ, LTS, LTE, GTS, GTE
   } alu_op_t;

   typedef struct packed {
      alu_op_t            code;
      logic [`IMM_W-1:0]  imm;
   } alu_inst_t;

   typedef enum logic [3:0] {
      DEV_ALU = 4'd0,
      DEV_REG = 4'd1,
      DEV_SEQ = 4'd2
   } dev_t;

   typedef enum logic [1:0] {STA, LDA, INC, DEC} reg_op_t;

   typedef enum logic [1:0] {HLT, JMP, JZ, JNZ} seq_op_t;

   typedef struct packed {
      dev_t        dev;
      logic [11:0] body;  // alu_inst_t, reg_body_t or seq_body_t
   } prog_word_t;

   typedef struct packed {
      reg_op_t               op;
      logic [6:0]            pad;
      logic [`REG_SEL_W-1:0] sel;
   } reg_body_t;

   typedef struct packed {
      seq_op_t          op;
      logic [1:0]       pad;
      logic [`PC_W-1:0] target;
   } seq_body_t;

   typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_HALT, SEQ_FAULT} seq_state_t;

   typedef struct packed {
      logic [`ACC_W-1:0] acc;
      logic              halted;
      logic              error;
   } core_status_t;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module alu (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 alu_en,
   input  accum_pkg::alu_inst_t alu_inst,
   output logic [`ACC_W-1:0]    acc,
   output logic                 ready,
   output logic                 error
);
   import accum_pkg::*;

   logic [1:0]        state;
   logic [`ACC_W-1:0] next_acc;

   always_comb begin
      case (alu_inst.code)
         NOP: next_acc = acc;
         LDI: next_acc = alu_inst.imm;
         ADD: next_acc = acc + alu_inst.imm;  // wraps mod 256
         SUB: next_acc = acc - alu_inst.imm;
         NOT: next_acc = ~acc;
         AND: next_acc = acc & alu_inst.imm;
         IOR: next_acc = acc | alu_inst.imm;
         XOR: next_acc = acc ^ alu_inst.imm;
         SHL: next_acc = acc << 1;  // zero fill
         SHR: next_acc = acc >> 1;
         EQL: next_acc = {{(`ACC_W-1){1'b0}}, (acc == alu_inst.imm)};
         NEQ: next_acc = {{(`ACC_W-1){1'b0}}, (acc != alu_inst.imm)};
         LTS: next_acc = {{(`ACC_W-1){1'b0}}, (acc < alu_inst.imm)};
         LTE: next_acc = {{(`ACC_W-1){1'b0}}, (acc <= alu_inst.imm)};
         GTS: next_acc = {{(`ACC_W-1){1'b0}}, (acc > alu_inst.imm)};
         GTE: next_acc = {{(`ACC_W-1){1'b0}}, (acc >= alu_inst.imm)};
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= `ALU_ST_RESET;
         acc   <= '0;
      end else begin
         case (state)
            `ALU_ST_RESET: begin
               state <= `ALU_ST_READY;  // one cycle in reset
               acc   <= '0;
            end
            `ALU_ST_READY: begin
               if (alu_en) begin
                  acc <= next_acc;
               end
            end
            default: begin
               // error and the unused code both land here and hold
               state <= `ALU_ST_ERROR;
               acc   <= '0;
            end
         endcase
      end
   end

   assign ready = (state == `ALU_ST_READY);
   assign error = (state == `ALU_ST_ERROR);

   a_state_legal: assert property (
      @(posedge clock) disable iff (reset)
      state inside {`ALU_ST_RESET, `ALU_ST_READY, `ALU_ST_ERROR}
   );

   // sequencer must never strobe before reset completes or after an error
   a_en_only_ready: assert property (
      @(posedge clock) disable iff (reset)
      alu_en |-> ready
   );

endmodule

// ==== hdl/prog_mem.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module prog_mem (
   input  logic                  clock,
   input  logic                  load_en,
   input  logic [`PC_W-1:0]      load_addr,
   input  accum_pkg::prog_word_t load_word,
   input  logic [`PC_W-1:0]      pc,
   output accum_pkg::prog_word_t word
);
   import accum_pkg::*;

   prog_word_t mem [`MEM_DEPTH];  // no reset, program is loaded from outside

   always_ff @(posedge clock) begin
      if (load_en) begin
         mem[load_addr] <= load_word;
      end
   end

   assign word = mem[pc];  // async read at the program counter

endmodule

// ==== hdl/reg_bank.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module reg_bank (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  reg_en,
   input  accum_pkg::reg_op_t    reg_op,
   input  logic [`REG_SEL_W-1:0] reg_sel,
   input  logic [`ACC_W-1:0]     acc,
   output logic [`ACC_W-1:0]     rd_data
);
   import accum_pkg::*;

   logic [`ACC_W-1:0] regs [`REG_N];

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < `REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_en) begin
         case (reg_op)
            STA: regs[reg_sel] <= acc;
            INC: regs[reg_sel] <= regs[reg_sel] + 1'b1;  // wraps
            DEC: regs[reg_sel] <= regs[reg_sel] - 1'b1;
            default: begin
               // lda only reads, through rd_data
            end
         endcase
      end
   end

   assign rd_data = regs[reg_sel];  // always the selected register

endmodule

// ==== hdl/seq_control.sv ====
`timescale 1ns/1ps
`include "accum_config.svh"

module seq_control (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  run,
   input  accum_pkg::prog_word_t word,
   output logic [`PC_W-1:0]      pc,
   input  logic [`ACC_W-1:0]     acc,
   input  logic [`ACC_W-1:0]     rd_data,
   input  logic                  alu_ready,
   input  logic                  alu_error,
   output logic                  alu_en,
   output accum_pkg::alu_inst_t  alu_inst,
   output logic                  reg_en,
   output accum_pkg::reg_op_t    reg_op,
   output logic [`REG_SEL_W-1:0] reg_sel,
   output logic                  halted,
   output logic                  error
);
   import accum_pkg::*;

   seq_state_t state;
   reg_body_t  reg_body;
   seq_body_t  seq_body;
   logic       active;
   logic       acc_zero;

   assign reg_body = reg_body_t'(word.body);
   assign seq_body = seq_body_t'(word.body);
   assign active   = (state == SEQ_RUN) && alu_ready;
   assign acc_zero = (acc == '0);

   // dispatch is combinational so results land on the next edge
   always_comb begin
      alu_en   = 1'b0;
      alu_inst = alu_inst_t'(word.body);
      reg_en   = 1'b0;
      reg_op   = reg_body.op;
      reg_sel  = reg_body.sel;
      if (active) begin
         case (word.dev)
            DEV_ALU: alu_en = 1'b1;
            DEV_REG: begin
               if (reg_body.op == LDA) begin
                  alu_en   = 1'b1;
                  alu_inst = '{code: LDI, imm: rd_data};  // lda is an ldi of the register
               end else begin
                  reg_en = 1'b1;
               end
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= SEQ_IDLE;
         pc    <= '0;
      end else begin
         case (state)
            SEQ_IDLE, SEQ_HALT: begin
               if (run && alu_ready) begin
                  state <= SEQ_RUN;
                  pc    <= '0;
               end
            end
            SEQ_RUN: begin
               if (alu_error) begin
                  state <= SEQ_FAULT;
               end else begin
                  case (word.dev)
                     DEV_ALU, DEV_REG: pc <= pc + 1'b1;
                     DEV_SEQ: begin
                        case (seq_body.op)
                           HLT: state <= SEQ_HALT;  // pc stays on the halt
                           JMP: pc <= seq_body.target;
                           JZ:  pc <= acc_zero ? seq_body.target : pc + 1'b1;
                           JNZ: pc <= acc_zero ? pc + 1'b1 : seq_body.target;
                        endcase
                     end
                     default: state <= SEQ_FAULT;  // illegal device
                  endcase
               end
            end
            default: state <= SEQ_FAULT;  // sticky until reset
         endcase
      end
   end

   assign halted = (state == SEQ_HALT) || (state == SEQ_FAULT);
   assign error  = (state == SEQ_FAULT);

   a_one_strobe: assert property (
      @(posedge clock) disable iff (reset)
      !(alu_en && reg_en)
   );

endmodule

// ==== project.f ====
+incdir+hdl
hdl/accum_pkg.sv
hdl/prog_mem.sv
hdl/reg_bank.sv
hdl/alu.sv
hdl/seq_control.sv
hdl/accum_core.sv
dv/accum_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module accum_core_tb -o accum_core_sim

out=$(./obj_dir/accum_core_sim)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
   exit 0
else
   exit 1
fi
